// ==== include/mmio_config.svh ====
// MMIO device port parameters

`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

//////////////////////////////////////////////////
// data path
//////////////////////////////////////////////////

`define MMIO_DATA_W 64

//////////////////////////////////////////////////
// device map
//////////////////////////////////////////////////

`define MMIO_ADDR_RTC      64'h0000_0000_a000_0048
`define MMIO_ADDR_MTIME    64'h0000_0000_0200_bff8
`define MMIO_ADDR_MTIMECMP 64'h0000_0000_0200_4000

// clock cycles per rtc tick, short for simulation.
`define MMIO_RTC_DIV 16

// all ones keeps the timer interrupt low out of reset.
`define MMIO_MTIMECMP_RST {`MMIO_DATA_W{1'b1}}

`endif

// ==== source/mmio_pkg.sv ====
// MMIO shared types

`include "mmio_config.svh"

package mmio_pkg;

  //////////////////////////////////////////////////
  // data word
  //////////////////////////////////////////////////

  // one bus word, also used for addresses.
  typedef logic [`MMIO_DATA_W-1:0] word_t;

  //////////////////////////////////////////////////
  // decoded target
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DEV_NONE,     // unmapped, reads zero.
    DEV_RTC,      // read only.
    DEV_MTIME,
    DEV_MTIMECMP
  } dev_sel_e;

endpackage

// ==== source/mmio_clint_if.sv ====
// CLINT register link

`timescale 1ns/1ps

interface mmio_clint_if;

  logic            sel_mtime;    // decode levels.
  logic            sel_mtimecmp;
  logic            wr;           // one cycle write strobe.
  mmio_pkg::word_t wdata;
  mmio_pkg::word_t mtime;        // register values.
  mmio_pkg::word_t mtimecmp;

  // decode side, owns the select and write signals.
  modport access (
    output sel_mtime,
    output sel_mtimecmp,
    output wr,
    output wdata,
    input  mtime,
    input  mtimecmp
  );

  modport device (
    input  sel_mtime,
    input  sel_mtimecmp,
    input  wr,
    input  wdata,
    output mtime,
    output mtimecmp
  );

endinterface

// ==== source/mmio_rtc.sv ====
// Real-time clock counter

`timescale 1ns/1ps

`include "mmio_config.svh"

module mmio_rtc (
  input  logic            clk,
  input  logic            rst,
  output mmio_pkg::word_t o_count
);

  localparam int PRE_W = (`MMIO_RTC_DIV > 1) ? $clog2(`MMIO_RTC_DIV) : 1;
  localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`MMIO_RTC_DIV - 1);

  logic [PRE_W-1:0] pre_q;
  logic             tick;
  mmio_pkg::word_t  count_q;

  //////////////////////////////////////////////////
  // prescaler
  //////////////////////////////////////////////////

  assign tick = (pre_q == PRE_LAST);  // last cycle of a period.

  always_ff @(posedge clk) begin
    if (rst) begin
      pre_q <= '0;
    end else if (tick) begin
      pre_q <= '0;
    end else begin
      pre_q <= pre_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // elapsed time
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (tick) begin
      count_q <= count_q + 1'b1;  // one tick per wrap.
    end
  end

  assign o_count = count_q;

endmodule

// ==== source/mmio_clint.sv ====
// CLINT timer registers

`timescale 1ns/1ps

`include "mmio_config.svh"

module mmio_clint (
  input  logic                clk,
  input  logic                rst,
  mmio_clint_if.device        bus,
  output logic                o_mtime_overflow
);

  mmio_pkg::word_t mtime_q;
  mmio_pkg::word_t mtimecmp_q;
  logic            wr_mtime;
  logic            wr_mtimecmp;

  //////////////////////////////////////////////////
  // write enables
  //////////////////////////////////////////////////

  // target already decoded on the access side.
  assign wr_mtime    = bus.wr & bus.sel_mtime;
  assign wr_mtimecmp = bus.wr & bus.sel_mtimecmp;

  //////////////////////////////////////////////////
  // mtime
  //////////////////////////////////////////////////

  // free running, a write replaces the increment.
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else if (wr_mtime) begin
      mtime_q <= bus.wdata;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // mtimecmp
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= `MMIO_MTIMECMP_RST;
    end else if (wr_mtimecmp) begin
      mtimecmp_q <= bus.wdata;  // changes only on a write.
    end
  end

  //////////////////////////////////////////////////
  // read values and interrupt
  //////////////////////////////////////////////////

  assign bus.mtime    = mtime_q;
  assign bus.mtimecmp = mtimecmp_q;

  // unsigned compare, machine timer interrupt level.
  assign o_mtime_overflow = (mtime_q >= mtimecmp_q);

endmodule

// ==== source/mmio_access.sv ====
// MMIO access port

`timescale 1ns/1ps

`include "mmio_config.svh"

module mmio_access (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic            i_ack,
  input  logic            i_ren,
  input  logic            i_wen,
  input  mmio_pkg::word_t i_addr,
  input  mmio_pkg::word_t i_wdata,
  output logic            o_req,
  output mmio_pkg::word_t o_rdata,
  output logic            o_mtime_overflow,
  mmio_clint_if.access    clint,
  mmio_clint_if.device    clint_dev
);

  mmio_pkg::dev_sel_e sel;
  mmio_pkg::word_t    rtc_count;
  mmio_pkg::word_t    sel_data;

  //////////////////////////////////////////////////
  // devices
  //////////////////////////////////////////////////

  mmio_rtc u_rtc (
    .clk     (clk),
    .rst     (rst),
    .o_count (rtc_count)
  );

  mmio_clint u_clint (
    .clk              (clk),
    .rst              (rst),
    .bus              (clint_dev),
    .o_mtime_overflow (o_mtime_overflow)
  );

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  always_comb begin
    case (i_addr)
      `MMIO_ADDR_RTC:      sel = mmio_pkg::DEV_RTC;
      `MMIO_ADDR_MTIME:    sel = mmio_pkg::DEV_MTIME;
      `MMIO_ADDR_MTIMECMP: sel = mmio_pkg::DEV_MTIMECMP;
      default:             sel = mmio_pkg::DEV_NONE;
    endcase
  end

  assign clint.sel_mtime    = (sel == mmio_pkg::DEV_MTIME);
  assign clint.sel_mtimecmp = (sel == mmio_pkg::DEV_MTIMECMP);
  assign clint.wr           = i_start & i_wen;  // rtc and unmapped writes fall away.
  assign clint.wdata        = i_wdata;

  // values from before the edge, so read-with-write sees old data.
  always_comb begin
    case (sel)
      mmio_pkg::DEV_RTC:      sel_data = rtc_count;
      mmio_pkg::DEV_MTIME:    sel_data = clint.mtime;
      mmio_pkg::DEV_MTIMECMP: sel_data = clint.mtimecmp;
      default:                sel_data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // req flag and read capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      o_req   <= 1'b0;
      o_rdata <= '0;
    end else if (i_start) begin
      o_req   <= 1'b1;  // start wins over ack.
      o_rdata <= i_ren ? sel_data : '0;
    end else if (i_ack) begin
      o_req   <= 1'b0;
      o_rdata <= '0;
    end
  end

endmodule

// ==== source/mmio_top.sv ====
// MMIO device port top

`timescale 1ns/1ps

module mmio_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic            i_ack,
  input  logic            i_ren,
  input  logic            i_wen,
  input  mmio_pkg::word_t i_addr,
  input  mmio_pkg::word_t i_wdata,
  output logic            o_req,
  output mmio_pkg::word_t o_rdata,
  output logic            o_mtime_overflow
);

  //////////////////////////////////////////////////
  // clint link
  //////////////////////////////////////////////////

  mmio_clint_if clint_if ();

  //////////////////////////////////////////////////
  // access block
  //////////////////////////////////////////////////

  // both ends of the link enter here, the clint sits inside.
  mmio_access u_access (
    .clk              (clk),
    .rst              (rst),
    .i_start          (i_start),
    .i_ack            (i_ack),
    .i_ren            (i_ren),
    .i_wen            (i_wen),
    .i_addr           (i_addr),
    .i_wdata          (i_wdata),
    .o_req            (o_req),
    .o_rdata          (o_rdata),
    .o_mtime_overflow (o_mtime_overflow),
    .clint            (clint_if.access),
    .clint_dev        (clint_if.device)
  );

endmodule

// ==== tb/mmio_tb.sv ====
// MMIO device port testbench

`timescale 1ns/1ps

`include "mmio_config.svh"

module mmio_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int RST_CYCLES  = 10;
  localparam int MAX_ENTRIES = 24;
  localparam int MARGIN      = 8;  // cycles per entry beyond gap and ack delay.

  localparam mmio_pkg::word_t ADDR_UNMAPPED = 64'h0000_0000_0200_0010;
  localparam mmio_pkg::word_t CMP_FAR       = 64'h4000_0000_0000_0000;

  typedef struct {
    logic               ren;
    logic               wen;
    mmio_pkg::word_t    addr;
    mmio_pkg::word_t    wdata;
    mmio_pkg::dev_sel_e kind;   // expected target.
    int                 gap;
    int                 ack_dly;
  } access_t;

  logic            clk;
  logic            rst;
  logic            i_start;
  logic            i_ack;
  logic            i_ren;
  logic            i_wen;
  mmio_pkg::word_t i_addr;
  mmio_pkg::word_t i_wdata;
  logic            o_req;
  mmio_pkg::word_t o_rdata;
  logic            o_mtime_overflow;

  access_t         tbl [MAX_ENTRIES];
  int              n_entries    = 0;
  logic [63:0]     rng_state    = 64'd91166;
  longint          limit_cycles = 0;
  longint unsigned edge_cnt     = 0;

  // reference model state.
  mmio_pkg::word_t mt_base     = '0;
  longint unsigned mt_base_cnt = 0;
  mmio_pkg::word_t cmp_model   = `MMIO_MTIMECMP_RST;

  mmio_top UUT (
    .clk              (clk),
    .rst              (rst),
    .i_start          (i_start),
    .i_ack            (i_ack),
    .i_ren            (i_ren),
    .i_wen            (i_wen),
    .i_addr           (i_addr),
    .i_wdata          (i_wdata),
    .o_req            (o_req),
    .o_rdata          (o_rdata),
    .o_mtime_overflow (o_mtime_overflow)
  );

  //////////////////////////////////////////////////
  // clock, edge count, watchdog
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst) begin
      edge_cnt <= edge_cnt + 1;  // edges seen out of reset.
    end
  end

  initial begin
    wait (limit_cycles != 0);
    #(limit_cycles * CLK_PERIOD);
    $display("run timed out after %0d cycles without finishing", limit_cycles);
    $display("tests failed");
    $fatal(1);
  end

  //////////////////////////////////////////////////
  // model and helpers
  //////////////////////////////////////////////////

  function automatic logic [63:0] next_rand();
    logic [63:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    rng_state = x;
    return x;
  endfunction

  function automatic mmio_pkg::word_t mtime_at(input longint unsigned n);
    return mt_base + mmio_pkg::word_t'(n - mt_base_cnt);
  endfunction

  function automatic mmio_pkg::word_t expected_read(input mmio_pkg::dev_sel_e kind,
                                                    input longint unsigned n);
    case (kind)
      mmio_pkg::DEV_RTC:      return mmio_pkg::word_t'(n / `MMIO_RTC_DIV);
      mmio_pkg::DEV_MTIME:    return mtime_at(n);
      mmio_pkg::DEV_MTIMECMP: return cmp_model;
      default:                return '0;
    endcase
  endfunction

  // n is the edge count once the write edge has passed.
  task automatic apply_write(input mmio_pkg::dev_sel_e kind, input mmio_pkg::word_t wdata,
                             input longint unsigned n);
    if (kind == mmio_pkg::DEV_MTIME) begin
      mt_base     = wdata;
      mt_base_cnt = n;
    end else if (kind == mmio_pkg::DEV_MTIMECMP) begin
      cmp_model = wdata;
    end
  endtask

  task automatic add_entry(input logic ren, input logic wen, input mmio_pkg::dev_sel_e kind,
                           input mmio_pkg::word_t addr, input mmio_pkg::word_t wdata);
    tbl[n_entries].ren     = ren;
    tbl[n_entries].wen     = wen;
    tbl[n_entries].kind    = kind;
    tbl[n_entries].addr    = addr;
    tbl[n_entries].wdata   = wdata;
    tbl[n_entries].gap     = int'(next_rand() % 6);
    tbl[n_entries].ack_dly = int'(next_rand() % 4);
    n_entries++;
  endtask

  task automatic build_table();
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_RTC,      `MMIO_ADDR_RTC,      '0);
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_MTIME,    `MMIO_ADDR_MTIME,    '0);
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_MTIMECMP, `MMIO_ADDR_MTIMECMP, '0);
    add_entry(1'b0, 1'b1, mmio_pkg::DEV_MTIME,    `MMIO_ADDR_MTIME,
              next_rand() & 64'h0000_ffff_ffff_ffff);
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_MTIME,    `MMIO_ADDR_MTIME,    '0);
    add_entry(1'b0, 1'b1, mmio_pkg::DEV_MTIMECMP, `MMIO_ADDR_MTIMECMP, 64'd5);  // below mtime.
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_MTIMECMP, `MMIO_ADDR_MTIMECMP, '0);
    add_entry(1'b0, 1'b1, mmio_pkg::DEV_MTIMECMP, `MMIO_ADDR_MTIMECMP, CMP_FAR);
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_MTIMECMP, `MMIO_ADDR_MTIMECMP, '0);
    add_entry(1'b0, 1'b1, mmio_pkg::DEV_RTC,      `MMIO_ADDR_RTC,      next_rand());
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_RTC,      `MMIO_ADDR_RTC,      '0);
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_NONE,     ADDR_UNMAPPED,       '0);
    add_entry(1'b0, 1'b1, mmio_pkg::DEV_NONE,     ADDR_UNMAPPED,       next_rand());
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_MTIMECMP, `MMIO_ADDR_MTIMECMP, '0);
    add_entry(1'b1, 1'b1, mmio_pkg::DEV_MTIMECMP, `MMIO_ADDR_MTIMECMP, next_rand());
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_MTIMECMP, `MMIO_ADDR_MTIMECMP, '0);
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_MTIME,    `MMIO_ADDR_MTIME,    '0);
    add_entry(1'b1, 1'b0, mmio_pkg::DEV_RTC,      `MMIO_ADDR_RTC,      '0);
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input mmio_pkg::word_t exp,
                            input mmio_pkg::word_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_levels(input logic exp_req);
    logic exp_ovf;
    exp_ovf = (mtime_at(edge_cnt) >= cmp_model);
    check_bit("o_req", exp_req, o_req);
    check_bit("o_mtime_overflow", exp_ovf, o_mtime_overflow);
  endtask

  //////////////////////////////////////////////////
  // one access
  //////////////////////////////////////////////////

  task automatic run_access(input access_t a);
    mmio_pkg::word_t exp_rdata;
    longint unsigned n;
    repeat (a.gap) @(posedge clk);
    @(posedge clk);
    i_start <= 1'b1;
    i_ren   <= a.ren;
    i_wen   <= a.wen;
    i_addr  <= a.addr;
    i_wdata <= a.wdata;
    @(negedge clk);
    n = edge_cnt;  // state that the start edge will capture.
    exp_rdata = a.ren ? expected_read(a.kind, n) : '0;
    check_levels(1'b0);
    @(posedge clk);
    i_start <= 1'b0;
    i_ren   <= 1'b0;
    i_wen   <= 1'b0;
    if (a.wen) begin
      apply_write(a.kind, a.wdata, n + 1);
    end
    @(negedge clk);
    check_word("o_rdata", exp_rdata, o_rdata);
    check_levels(1'b1);
    repeat (a.ack_dly) begin
      @(posedge clk);
      @(negedge clk);
      check_word("o_rdata", exp_rdata, o_rdata);
      check_levels(1'b1);
    end
    @(posedge clk);
    i_ack <= 1'b1;
    @(negedge clk);
    check_word("o_rdata", exp_rdata, o_rdata);  // ack not sampled yet.
    check_levels(1'b1);
    @(posedge clk);
    i_ack <= 1'b0;
    @(negedge clk);
    check_word("o_rdata", '0, o_rdata);
    check_levels(1'b0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    longint cycles;
    rst     = 1'b1;
    i_start = 1'b0;
    i_ack   = 1'b0;
    i_ren   = 1'b0;
    i_wen   = 1'b0;
    i_addr  = '0;
    i_wdata = '0;
    build_table();
    cycles = RST_CYCLES + 20;
    for (int i = 0; i < n_entries; i++) begin
      cycles += tbl[i].gap + tbl[i].ack_dly + MARGIN;
    end
    limit_cycles = cycles;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_word("o_rdata", '0, o_rdata);
    check_levels(1'b0);
    for (int i = 0; i < n_entries; i++) begin
      run_access(tbl[i]);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
source/mmio_pkg.sv
source/mmio_clint_if.sv
source/mmio_rtc.sv
source/mmio_clint.sv
source/mmio_access.sv
source/mmio_top.sv
tb/mmio_tb.sv

// ==== Bender.yml ====
package:
  name: mmio

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/mmio_pkg.sv
      - source/mmio_clint_if.sv
      - source/mmio_rtc.sv
      - source/mmio_clint.sv
      - source/mmio_access.sv
      - source/mmio_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/mmio_tb.sv
